// ==== Makefile ====
SIM  := obj_dir/Vtb_ti_sdram_glue
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

$(SIM): filelist.f $(SRCS)
	verilator --binary --assert --timing -Wno-fatal --top-module tb_ti_sdram_glue -f filelist.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== design/cpu_mem_port.sv ====
`default_nettype none

module cpu_mem_port
    import ti_glue_pkg::*;
(
    input  wire cpu_addr_t cpu_ram_a_i,
    input  wire            cpu_ram_ce_n_i,
    input  wire            cpu_ram_we_n_i,
    input  wire lanes_t    cpu_ram_be_n_i,
    input  wire word_t     cpu_ram_d_i,
    mem_req_if.source      cpu_req
);

    // ------------------------------
    // Access decode
    // ------------------------------
    assign cpu_req.we = !cpu_ram_ce_n_i && !cpu_ram_we_n_i;
    assign cpu_req.rd = !cpu_ram_ce_n_i && cpu_ram_we_n_i;

    // Word address to byte address in the low SDRAM area
    assign cpu_req.addr = {{(SDRAM_AW - CPU_AW - 1){1'b0}}, cpu_ram_a_i, 1'b0};

    // Enables from the core are active low
    assign cpu_req.lanes = ~cpu_ram_be_n_i;
    assign cpu_req.din   = cpu_ram_d_i;

endmodule

`default_nettype wire

// ==== design/glue_ctrl.sv ====
`default_nettype none

module glue_ctrl
    import ti_glue_pkg::*;
(
    input  wire         clk_sys,
    input  wire         reset,
    input  wire         pll_locked_i,
    input  wire         status_reset_i,
    input  wire         reset_button_i,
    input  wire         downl_i,
    output logic        core_reset_o,
    output logic        clk_en_10m7_o,
    output ctrl_state_e state_o
);

    logic [CLK_EN_W-1:0] clk_cnt;

    // ------------------------------
    // Core reset
    // ------------------------------
    // Core is held while loading ROMs or while the PLL is unlocked
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            core_reset_o <= 1'b1;
        end else begin
            core_reset_o <= status_reset_i || reset_button_i || downl_i || !pll_locked_i;
        end
    end

    // ------------------------------
    // Source selection state
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state_o <= ST_RUN;
        end else if (downl_i) begin
            state_o <= ST_LOAD;
        end else begin
            state_o <= ST_RUN;
        end
    end

    // ------------------------------
    // Clock enable divider
    // ------------------------------
    // One pulse per CLK_EN_DIV system clocks
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            clk_cnt       <= '0;
            clk_en_10m7_o <= 1'b0;
        end else begin
            if (clk_cnt == CLK_EN_W'(CLK_EN_DIV - 1)) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            clk_en_10m7_o <= (clk_cnt == CLK_EN_W'(CLK_EN_DIV - 1));
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_req_if.sv ====
`default_nettype none

// One access source as seen by the SDRAM requester
interface mem_req_if
    import ti_glue_pkg::*;
();

    // Byte address into SDRAM
    sdram_addr_t addr;
    word_t       din;
    // Active-high byte lanes, upper lane in bit 1
    lanes_t      lanes;
    // Level strobes, a rising edge starts an access
    logic        we;
    logic        rd;

    modport source (
        output addr,
        output din,
        output lanes,
        output we,
        output rd
    );

    modport sink (
        input addr,
        input din,
        input lanes,
        input we,
        input rd
    );

endinterface

`default_nettype wire

// ==== design/rom_loader.sv ====
`default_nettype none

module rom_loader
    import ti_glue_pkg::*;
(
    input  wire              clk_sys,
    input  wire              reset,
    input  wire              downl_i,
    input  wire img_index_t  index_i,
    input  wire              rom_wr_i,
    input  wire sdram_addr_t romwr_a_i,
    input  wire byte_t       ioctl_dout_i,
    mem_req_if.source        dl_req,
    output rommask_t         rommask_o
);

    img_type_e   img_type;
    sdram_addr_t region_ofs;
    rommask_t    mask_next;

    // ------------------------------
    // Image type and region offset
    // ------------------------------
    always_comb begin
        case (index_i)
            IDX_C0, IDX_C1: img_type = IMG_C;
            IDX_D0, IDX_D1: img_type = IMG_D;
            IDX_G0, IDX_G1: img_type = IMG_G;
            default:        img_type = IMG_ROM;
        endcase
    end

    always_comb begin
        case (img_type)
            IMG_C:   region_ofs = '0;
            IMG_D:   region_ofs = OFS_D;
            IMG_G:   region_ofs = OFS_G;
            default: region_ofs = OFS_ROM;
        endcase
    end

    // Byte stream goes out on both halves, lane picked by address bit 0
    assign dl_req.addr  = romwr_a_i + region_ofs;
    assign dl_req.din   = {ioctl_dout_i, ioctl_dout_i};
    assign dl_req.lanes = {~romwr_a_i[0], romwr_a_i[0]};
    assign dl_req.we    = rom_wr_i;
    assign dl_req.rd    = 1'b0;

    // ------------------------------
    // Cartridge bank mask
    // ------------------------------
    // D images size the mask by the highest address written
    always_comb begin
        if (img_type != IMG_D) begin
            mask_next = MASK_ALL;
        end else if (romwr_a_i[SDRAM_AW-1:14] == '0) begin
            mask_next = 6'b000001;
        end else if (romwr_a_i[SDRAM_AW-1:15] == '0) begin
            mask_next = 6'b000011;
        end else if (romwr_a_i[SDRAM_AW-1:16] == '0) begin
            mask_next = 6'b000111;
        end else if (romwr_a_i[SDRAM_AW-1:17] == '0) begin
            mask_next = 6'b001111;
        end else if (romwr_a_i[SDRAM_AW-1:18] == '0) begin
            mask_next = 6'b011111;
        end else begin
            mask_next = MASK_ALL;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rommask_o <= MASK_ALL;
        end else if (downl_i && rom_wr_i) begin
            rommask_o <= mask_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/sdram_requester.sv ====
`default_nettype none

module sdram_requester
    import ti_glue_pkg::*;
(
    input  wire              clk_sys,
    input  wire              reset,
    input  wire ctrl_state_e state_i,
    mem_req_if.sink          cpu_req,
    mem_req_if.sink          dl_req,
    output logic             sdram_req_o,
    output logic             sdram_we_o,
    output sdram_addr_t      sdram_addr_o,
    output lanes_t           sdram_bs_o,
    output word_t            sdram_din_o
);

    sdram_addr_t sel_addr;
    word_t       sel_din;
    lanes_t      sel_lanes;
    logic        sel_we;
    logic        sel_rd;
    logic        we_d;
    logic        rd_d;
    logic        new_access;

    // ------------------------------
    // Source select
    // ------------------------------
    always_comb begin
        if (state_i == ST_LOAD) begin
            sel_addr  = dl_req.addr;
            sel_din   = dl_req.din;
            sel_lanes = dl_req.lanes;
            sel_we    = dl_req.we;
            sel_rd    = dl_req.rd;
        end else begin
            sel_addr  = cpu_req.addr;
            sel_din   = cpu_req.din;
            sel_lanes = cpu_req.lanes;
            sel_we    = cpu_req.we;
            sel_rd    = cpu_req.rd;
        end
    end

    assign new_access = (sel_we && !we_d) || (sel_rd && !rd_d);

    // Toggle handshake, the controller compares req against its own ack
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            we_d         <= 1'b0;
            rd_d         <= 1'b0;
            sdram_req_o  <= 1'b0;
            sdram_we_o   <= 1'b0;
            sdram_addr_o <= '0;
            sdram_bs_o   <= '0;
            sdram_din_o  <= '0;
        end else begin
            we_d <= sel_we;
            rd_d <= sel_rd;
            if (new_access) begin
                sdram_req_o  <= ~sdram_req_o;
                sdram_we_o   <= sel_we;
                sdram_addr_o <= sel_addr;
                sdram_bs_o   <= sel_lanes;
                sdram_din_o  <= sel_din;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ti_glue_pkg.sv ====
`default_nettype none

package ti_glue_pkg;

    // ------------------------------
    // Widths and clock enable
    // ------------------------------
    localparam int SDRAM_AW   = 25;
    localparam int CPU_AW     = 19;
    localparam int CLK_EN_DIV = 4;
    localparam int CLK_EN_W   = $clog2(CLK_EN_DIV);

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [CPU_AW-1:0]   cpu_addr_t;
    typedef logic [15:0]         word_t;
    typedef logic [7:0]          byte_t;
    typedef logic [1:0]          lanes_t;
    typedef logic [5:0]          rommask_t;
    typedef logic [7:0]          img_index_t;

    // Kind of image being downloaded
    typedef enum logic [1:0] {
        IMG_C,
        IMG_D,
        IMG_G,
        IMG_ROM
    } img_type_e;

    typedef enum logic {
        ST_RUN,
        ST_LOAD
    } ctrl_state_e;

    // ------------------------------
    // Download index codes
    // ------------------------------
    localparam img_index_t IDX_C0 = 8'h01;
    localparam img_index_t IDX_C1 = 8'h02;
    localparam img_index_t IDX_D0 = 8'h03;
    localparam img_index_t IDX_D1 = 8'h41;
    localparam img_index_t IDX_G0 = 8'h04;
    localparam img_index_t IDX_G1 = 8'h81;

    // Region offsets, cartridge sits at zero
    localparam sdram_addr_t OFS_D   = 25'h000_2000;
    localparam sdram_addr_t OFS_G   = 25'h008_6000;
    localparam sdram_addr_t OFS_ROM = 25'h008_0000;

    localparam rommask_t MASK_ALL = 6'b111111;

endpackage

`default_nettype wire

// ==== design/ti_sdram_glue.sv ====
`default_nettype none

module ti_sdram_glue
    import ti_glue_pkg::*;
(
    input  wire              clk_sys,
    input  wire              reset,
    input  wire              pll_locked_i,
    input  wire              status_reset_i,
    input  wire              reset_button_i,
    // ROM download port
    input  wire              downl_i,
    input  wire img_index_t  index_i,
    input  wire              rom_wr_i,
    input  wire sdram_addr_t romwr_a_i,
    input  wire byte_t       ioctl_dout_i,
    // CPU RAM port of the core
    input  wire cpu_addr_t   cpu_ram_a_i,
    input  wire              cpu_ram_ce_n_i,
    input  wire              cpu_ram_we_n_i,
    input  wire lanes_t      cpu_ram_be_n_i,
    input  wire word_t       cpu_ram_d_i,
    // Core control
    output logic             core_reset_o,
    output logic             clk_en_10m7_o,
    output rommask_t         rommask_o,
    // Toggle request toward the SDRAM controller
    output logic             sdram_req_o,
    output logic             sdram_we_o,
    output sdram_addr_t      sdram_addr_o,
    output lanes_t           sdram_bs_o,
    output word_t            sdram_din_o
);

    ctrl_state_e state;

    mem_req_if cpu_req ();
    mem_req_if dl_req ();

    glue_ctrl u_glue_ctrl (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .pll_locked_i   (pll_locked_i),
        .status_reset_i (status_reset_i),
        .reset_button_i (reset_button_i),
        .downl_i        (downl_i),
        .core_reset_o   (core_reset_o),
        .clk_en_10m7_o  (clk_en_10m7_o),
        .state_o        (state)
    );

    rom_loader u_rom_loader (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .downl_i      (downl_i),
        .index_i      (index_i),
        .rom_wr_i     (rom_wr_i),
        .romwr_a_i    (romwr_a_i),
        .ioctl_dout_i (ioctl_dout_i),
        .dl_req       (dl_req.source),
        .rommask_o    (rommask_o)
    );

    cpu_mem_port u_cpu_mem_port (
        .cpu_ram_a_i    (cpu_ram_a_i),
        .cpu_ram_ce_n_i (cpu_ram_ce_n_i),
        .cpu_ram_we_n_i (cpu_ram_we_n_i),
        .cpu_ram_be_n_i (cpu_ram_be_n_i),
        .cpu_ram_d_i    (cpu_ram_d_i),
        .cpu_req        (cpu_req.source)
    );

    sdram_requester u_sdram_requester (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .state_i      (state),
        .cpu_req      (cpu_req.sink),
        .dl_req       (dl_req.sink),
        .sdram_req_o  (sdram_req_o),
        .sdram_we_o   (sdram_we_o),
        .sdram_addr_o (sdram_addr_o),
        .sdram_bs_o   (sdram_bs_o),
        .sdram_din_o  (sdram_din_o)
    );

endmodule

`default_nettype wire

// ==== filelist.f ====
design/ti_glue_pkg.sv
design/mem_req_if.sv
design/glue_ctrl.sv
design/rom_loader.sv
design/cpu_mem_port.sv
design/sdram_requester.sv
design/ti_sdram_glue.sv
test/ti_sdram_glue_props.sv
test/tb_ti_sdram_glue.sv

// ==== test/tb_ti_sdram_glue.sv ====
`default_nettype none

module tb_ti_sdram_glue
    import ti_glue_pkg::*;
();

    localparam int NUM_CPU    = 150;
    localparam int NUM_DL     = 120;
    localparam int LEN_RESET  = 40;
    localparam int LEN_CLKEN  = 20;
    localparam int LEN_CPU    = NUM_CPU * 3 + 20;
    localparam int LEN_DL     = NUM_DL * 2 + 10;
    localparam int LEN_MASK   = 30;
    localparam int LEN_SWITCH = 40;
    localparam int MAX_CYCLES =
        2 * (LEN_RESET + LEN_CLKEN + LEN_CPU + LEN_DL + LEN_MASK + LEN_SWITCH);

    logic        clk_sys;
    logic        reset;
    logic        pll_locked_i;
    logic        status_reset_i;
    logic        reset_button_i;
    logic        downl_i;
    img_index_t  index_i;
    logic        rom_wr_i;
    sdram_addr_t romwr_a_i;
    byte_t       ioctl_dout_i;
    cpu_addr_t   cpu_ram_a_i;
    logic        cpu_ram_ce_n_i;
    logic        cpu_ram_we_n_i;
    lanes_t      cpu_ram_be_n_i;
    word_t       cpu_ram_d_i;
    logic        core_reset_o;
    logic        clk_en_10m7_o;
    rommask_t    rommask_o;
    logic        sdram_req_o;
    logic        sdram_we_o;
    sdram_addr_t sdram_addr_o;
    lanes_t      sdram_bs_o;
    word_t       sdram_din_o;

    // Reference model state
    logic        exp_core_reset;
    logic        exp_clk_en;
    logic        exp_load;
    int          run_cycles;
    logic        exp_req;
    logic        exp_we;
    sdram_addr_t exp_addr;
    lanes_t      exp_bs;
    word_t       exp_din;
    rommask_t    exp_mask;
    logic        prev_we;
    logic        prev_rd;

    int          errors;
    int          tests_run;
    int          tests_bad;
    int          cycles;
    logic        checking;

    ti_sdram_glue u_ti_sdram_glue (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .pll_locked_i   (pll_locked_i),
        .status_reset_i (status_reset_i),
        .reset_button_i (reset_button_i),
        .downl_i        (downl_i),
        .index_i        (index_i),
        .rom_wr_i       (rom_wr_i),
        .romwr_a_i      (romwr_a_i),
        .ioctl_dout_i   (ioctl_dout_i),
        .cpu_ram_a_i    (cpu_ram_a_i),
        .cpu_ram_ce_n_i (cpu_ram_ce_n_i),
        .cpu_ram_we_n_i (cpu_ram_we_n_i),
        .cpu_ram_be_n_i (cpu_ram_be_n_i),
        .cpu_ram_d_i    (cpu_ram_d_i),
        .core_reset_o   (core_reset_o),
        .clk_en_10m7_o  (clk_en_10m7_o),
        .rommask_o      (rommask_o),
        .sdram_req_o    (sdram_req_o),
        .sdram_we_o     (sdram_we_o),
        .sdram_addr_o   (sdram_addr_o),
        .sdram_bs_o     (sdram_bs_o),
        .sdram_din_o    (sdram_din_o)
    );

    always #5 clk_sys = ~clk_sys;

    // ------------------------------
    // Model rules
    // ------------------------------
    function automatic sdram_addr_t region_base(input img_index_t idx);
        if (idx == IDX_C0 || idx == IDX_C1) begin
            return 25'h0;
        end
        if (idx == IDX_D0 || idx == IDX_D1) begin
            return 25'h2000;
        end
        if (idx == IDX_G0 || idx == IDX_G1) begin
            return 25'h8_6000;
        end
        return 25'h8_0000;
    endfunction

    // Bank mask sized by the D image address thresholds
    function automatic rommask_t mask_for(input img_index_t idx, input sdram_addr_t a);
        if (idx != IDX_D0 && idx != IDX_D1) begin
            return 6'b111111;
        end
        if (a < 25'h4000) begin
            return 6'b000001;
        end
        if (a < 25'h8000) begin
            return 6'b000011;
        end
        if (a < 25'h1_0000) begin
            return 6'b000111;
        end
        if (a < 25'h2_0000) begin
            return 6'b001111;
        end
        if (a < 25'h4_0000) begin
            return 6'b011111;
        end
        return 6'b111111;
    endfunction

    function automatic img_index_t pick_index();
        case ($urandom % 8)
            0:       return IDX_C0;
            1:       return IDX_C1;
            2:       return IDX_D0;
            3:       return IDX_D1;
            4:       return IDX_G0;
            5:       return IDX_G1;
            default: return img_index_t'($urandom);
        endcase
    endfunction

    always @(posedge clk_sys) begin : model
        sdram_addr_t s_addr;
        word_t       s_din;
        lanes_t      s_lanes;
        logic        s_we;
        logic        s_rd;
        // Source as seen by the state before this edge
        if (exp_load) begin
            s_we    = rom_wr_i;
            s_rd    = 1'b0;
            s_addr  = romwr_a_i + region_base(index_i);
            s_din   = {ioctl_dout_i, ioctl_dout_i};
            s_lanes = romwr_a_i[0] ? 2'b01 : 2'b10;
        end else begin
            s_we    = !cpu_ram_ce_n_i && !cpu_ram_we_n_i;
            s_rd    = !cpu_ram_ce_n_i && cpu_ram_we_n_i;
            s_addr  = sdram_addr_t'(cpu_ram_a_i) << 1;
            s_din   = cpu_ram_d_i;
            s_lanes = ~cpu_ram_be_n_i;
        end
        if (reset) begin
            exp_core_reset <= 1'b1;
            exp_clk_en     <= 1'b0;
            exp_load       <= 1'b0;
            run_cycles     <= 0;
            exp_req        <= 1'b0;
            exp_we         <= 1'b0;
            exp_addr       <= '0;
            exp_bs         <= '0;
            exp_din        <= '0;
            exp_mask       <= 6'b111111;
            prev_we        <= 1'b0;
            prev_rd        <= 1'b0;
        end else begin
            exp_core_reset <= status_reset_i || reset_button_i || downl_i || !pll_locked_i;
            exp_load       <= downl_i;
            run_cycles     <= run_cycles + 1;
            exp_clk_en     <= ((run_cycles + 1) % CLK_EN_DIV) == 0;
            prev_we        <= s_we;
            prev_rd        <= s_rd;
            if ((s_we && !prev_we) || (s_rd && !prev_rd)) begin
                exp_req  <= !exp_req;
                exp_we   <= s_we;
                exp_addr <= s_addr;
                exp_bs   <= s_lanes;
                exp_din  <= s_din;
            end
            if (downl_i && rom_wr_i) begin
                exp_mask <= mask_for(index_i, romwr_a_i);
            end
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_lanes(input string name, input lanes_t got, input lanes_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input rommask_t got, input rommask_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Every output against the model on the falling edge
    always @(negedge clk_sys) begin
        if (checking) begin
            check_bit("core_reset_o", core_reset_o, exp_core_reset);
            check_bit("clk_en_10m7_o", clk_en_10m7_o, exp_clk_en);
            check_mask("rommask_o", rommask_o, exp_mask);
            check_bit("sdram_req_o", sdram_req_o, exp_req);
            check_bit("sdram_we_o", sdram_we_o, exp_we);
            check_addr("sdram_addr_o", sdram_addr_o, exp_addr);
            check_lanes("sdram_bs_o", sdram_bs_o, exp_bs);
            check_word("sdram_din_o", sdram_din_o, exp_din);
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped, no finish after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------
    // Test helpers
    // ------------------------------
    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %-14s ok", name);
        end else begin
            tests_bad++;
            $display("test %-14s %0d mismatches", name, errors - start_errors);
        end
    endtask

    task automatic download_write(input img_index_t idx, input sdram_addr_t addr,
                                  input byte_t data);
        @(posedge clk_sys);
        index_i      <= idx;
        romwr_a_i    <= addr;
        ioctl_dout_i <= data;
        rom_wr_i     <= 1'b1;
        @(posedge clk_sys);
        rom_wr_i     <= 1'b0;
    endtask

    task automatic set_download(input logic on);
        @(posedge clk_sys);
        downl_i <= on;
        repeat (2) @(posedge clk_sys);
    endtask

    task automatic cpu_random();
        cpu_ram_a_i    <= cpu_addr_t'($urandom);
        cpu_ram_d_i    <= word_t'($urandom);
        cpu_ram_be_n_i <= lanes_t'($urandom);
        cpu_ram_we_n_i <= 1'($urandom);
        cpu_ram_ce_n_i <= ($urandom % 4) == 0;
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic verify_reset_sources();
        int start;
        start = errors;
        @(negedge clk_sys);
        check_bit("sdram_req_o", sdram_req_o, 1'b0);
        check_addr("sdram_addr_o", sdram_addr_o, '0);
        check_mask("rommask_o", rommask_o, 6'b111111);
        for (int src = 0; src < 4; src++) begin
            @(posedge clk_sys);
            status_reset_i <= (src == 0);
            reset_button_i <= (src == 1);
            downl_i        <= (src == 2);
            pll_locked_i   <= (src != 3);
            @(posedge clk_sys);
            status_reset_i <= 1'b0;
            reset_button_i <= 1'b0;
            downl_i        <= 1'b0;
            pll_locked_i   <= 1'b1;
            @(negedge clk_sys);
            check_bit("core_reset_o", core_reset_o, 1'b1);
            @(negedge clk_sys);
            check_bit("core_reset_o", core_reset_o, 1'b0);
        end
        finish_test("reset_sources", start);
    endtask

    task automatic measure_clk_enable();
        int start;
        int pulses;
        start  = errors;
        pulses = 0;
        repeat (16) begin
            @(negedge clk_sys);
            if (clk_en_10m7_o) begin
                pulses++;
            end
        end
        if (pulses != 4) begin
            $display("Clock enable pulsed %0d times in 16 cycles instead of 4", pulses);
            errors++;
        end
        finish_test("clk_enable", start);
    endtask

    task automatic random_cpu_accesses();
        int   start;
        logic req_before;
        start = errors;
        for (int n = 0; n < NUM_CPU; n++) begin
            @(posedge clk_sys);
            cpu_random();
            repeat ($urandom % 3) @(posedge clk_sys);
        end
        // One write held for several cycles
        @(posedge clk_sys);
        cpu_ram_ce_n_i <= 1'b1;
        @(negedge clk_sys);
        req_before = exp_req;
        @(posedge clk_sys);
        cpu_ram_ce_n_i <= 1'b0;
        cpu_ram_we_n_i <= 1'b0;
        repeat (5) @(posedge clk_sys);
        cpu_ram_ce_n_i <= 1'b1;
        @(negedge clk_sys);
        check_bit("sdram_req_o", sdram_req_o, !req_before);
        finish_test("cpu_access", start);
    endtask

    task automatic random_downloads();
        int start;
        start = errors;
        set_download(1'b1);
        for (int n = 0; n < NUM_DL; n++) begin
            download_write(pick_index(), sdram_addr_t'($urandom % 32'h10_0000),
                           byte_t'($urandom));
        end
        set_download(1'b0);
        finish_test("download", start);
    endtask

    task automatic sweep_rom_mask();
        int          start;
        sdram_addr_t addrs[6];
        rommask_t    masks[6];
        start = errors;
        addrs = '{25'h0100, 25'h5000, 25'hC000, 25'h1_F000, 25'h3_F000, 25'h5_0000};
        masks = '{6'b000001, 6'b000011, 6'b000111, 6'b001111, 6'b011111, 6'b111111};
        set_download(1'b1);
        for (int n = 0; n < 6; n++) begin
            download_write((n % 2) ? IDX_D1 : IDX_D0, addrs[n], byte_t'(n));
            @(negedge clk_sys);
            check_mask("rommask_o", rommask_o, masks[n]);
        end
        download_write(IDX_D0, 25'h0010, 8'h5A);
        download_write(IDX_G0, 25'h0010, 8'hA5);
        @(negedge clk_sys);
        check_mask("rommask_o", rommask_o, 6'b111111);
        set_download(1'b0);
        finish_test("rom_mask", start);
    endtask

    task automatic switch_sources();
        int   start;
        logic req_before;
        start = errors;
        set_download(1'b1);
        @(negedge clk_sys);
        req_before = exp_req;
        repeat (20) begin
            @(posedge clk_sys);
            cpu_random();
        end
        // CPU write held across the end of the download
        @(posedge clk_sys);
        cpu_ram_ce_n_i <= 1'b0;
        cpu_ram_we_n_i <= 1'b0;
        @(negedge clk_sys);
        check_bit("sdram_req_o", sdram_req_o, req_before);
        // Core stays in reset for one edge after the download ends
        @(posedge clk_sys);
        downl_i <= 1'b0;
        @(negedge clk_sys);
        check_bit("core_reset_o", core_reset_o, 1'b1);
        check_bit("sdram_req_o", sdram_req_o, req_before);
        @(negedge clk_sys);
        check_bit("core_reset_o", core_reset_o, 1'b0);
        check_bit("sdram_req_o", sdram_req_o, req_before);
        // CPU source selected again, the held write is new to it
        @(negedge clk_sys);
        check_bit("sdram_req_o", sdram_req_o, !req_before);
        @(posedge clk_sys);
        cpu_ram_ce_n_i <= 1'b1;
        repeat (2) @(posedge clk_sys);
        finish_test("switch", start);
    endtask

    initial begin
        void'($urandom(4));
        clk_sys        = 1'b0;
        reset          = 1'b1;
        pll_locked_i   = 1'b1;
        status_reset_i = 1'b0;
        reset_button_i = 1'b0;
        downl_i        = 1'b0;
        index_i        = '0;
        rom_wr_i       = 1'b0;
        romwr_a_i      = '0;
        ioctl_dout_i   = '0;
        cpu_ram_a_i    = '0;
        cpu_ram_ce_n_i = 1'b1;
        cpu_ram_we_n_i = 1'b1;
        cpu_ram_be_n_i = '1;
        cpu_ram_d_i    = '0;
        errors         = 0;
        tests_run      = 0;
        tests_bad      = 0;
        cycles         = 0;
        checking       = 1'b0;
        repeat (3) @(posedge clk_sys);
        reset    <= 1'b0;
        checking <= 1'b1;
        verify_reset_sources();
        measure_clk_enable();
        random_cpu_accesses();
        random_downloads();
        sweep_rom_mask();
        switch_sources();
        $display("%0d tests run, %0d with mismatches, %0d mismatches in total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ti_sdram_glue_props.sv ====
`default_nettype none

module ti_sdram_glue_props
    import ti_glue_pkg::*;
(
    input wire              clk_sys,
    input wire              reset,
    input wire              downl_i,
    input wire              rom_wr_i,
    input wire              cpu_ram_ce_n_i,
    input wire              cpu_ram_we_n_i,
    input wire ctrl_state_e state,
    input wire              core_reset_o,
    input wire              clk_en_10m7_o,
    input wire              sdram_req_o
);

    logic src_we;
    logic src_rd;
    logic src_we_q;
    logic src_rd_q;
    logic started;

    // Strobes of whichever source the requester listens to
    assign src_we  = (state == ST_LOAD) ? rom_wr_i : (!cpu_ram_ce_n_i && !cpu_ram_we_n_i);
    assign src_rd  = (state == ST_LOAD) ? 1'b0 : (!cpu_ram_ce_n_i && cpu_ram_we_n_i);
    assign started = (src_we && !src_we_q) || (src_rd && !src_rd_q);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            src_we_q <= 1'b0;
            src_rd_q <= 1'b0;
        end else begin
            src_we_q <= src_we;
            src_rd_q <= src_rd;
        end
    end

    // ------------------------------
    // Properties
    // ------------------------------
    a_download_reset: assert property (@(posedge clk_sys) disable iff (reset)
        downl_i |=> core_reset_o)
        else $error("core reset low in the cycle after a download");

    a_clk_en_single: assert property (@(posedge clk_sys) disable iff (reset)
        clk_en_10m7_o |=> !clk_en_10m7_o)
        else $error("clock enable high on two cycles in a row");

    a_req_needs_edge: assert property (@(posedge clk_sys) disable iff (reset)
        (sdram_req_o != $past(sdram_req_o)) |-> $past(started))
        else $error("SDRAM request toggled with no new access");

endmodule

bind ti_sdram_glue ti_sdram_glue_props u_props (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .downl_i        (downl_i),
    .rom_wr_i       (rom_wr_i),
    .cpu_ram_ce_n_i (cpu_ram_ce_n_i),
    .cpu_ram_we_n_i (cpu_ram_we_n_i),
    .state          (state),
    .core_reset_o   (core_reset_o),
    .clk_en_10m7_o  (clk_en_10m7_o),
    .sdram_req_o    (sdram_req_o)
);

`default_nettype wire
